/* Makefile */
# Verilator build and run for the upstream request multiplexer

SRCS := $(shell grep -v '^+' files.f)

obj_dir/VtxMuxTb: files.f $(SRCS) hw/txMuxSettings.svh
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module txMuxTb -o VtxMuxTb

run: obj_dir/VtxMuxTb
	./obj_dir/VtxMuxTb | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* files.f */
+incdir+hw
hw/txMuxPkg.sv
hw/reqSelector.sv
hw/reqCapture.sv
hw/txIssue.sv
hw/txMux.sv
tests/txMuxTb.sv

/* hw/reqCapture.sv */
// Request capture FSM that alternates read and write candidates and holds the accepted one
`default_nettype none
`timescale 1ns/1ps
`include "txMuxSettings.svh"

module reqCapture (
    input  wire logic                          CLK,
    input  wire logic                          rstN,
    input  wire logic                          rdValid,
    input  wire txMuxPkg::chnlT                rdChnl,
    input  wire txMuxPkg::rdPayloadT           rdPayload,
    input  wire logic                          wrValid,
    input  wire txMuxPkg::chnlT                wrChnl,
    input  wire txMuxPkg::wrPayloadT           wrPayload,
    input  wire logic [`TXMUX_EXT_TAG_W-1:0]   extTag,
    input  wire logic                          extTagValid,
    input  wire logic                          rxBufSpaceAvail,
    input  wire logic                          issueTake,
    output logic [`TXMUX_NUM_CHNL-1:0]         rdAck,
    output logic [`TXMUX_NUM_CHNL-1:0]         wrAck,
    output logic [`TXMUX_INT_TAG_W-1:0]        intTag,
    output logic                               intTagValid,
    output logic                               rdReqSent,
    output logic                               capPending,
    output logic                               capIsWr,
    output txMuxPkg::chnlT                     capChnl,
    output txMuxPkg::addrT                     capAddr,
    output txMuxPkg::lenT                      capLen,
    output logic [`TXMUX_META_TAG_W-1:0]       capTag
);

    typedef enum logic [1:0] {
        RD_CHK,
        WR_CHK,
        CAP,
        REL
    } capStateE;

    capStateE state;
    logic     rdAccept;
    logic     wrAccept;
    logic     tagTaken;     // External tag latched for the held request

    // Reads need a free tag and room for the completion
    assign rdAccept   = (state == RD_CHK) && rdValid && extTagValid && rxBufSpaceAvail;
    assign wrAccept   = (state == WR_CHK) && wrValid;
    assign capPending = (state == REL) && tagTaken;

    // -----------------------------------------------
    // Capture FSM
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            state       <= RD_CHK;
            rdAck       <= '0;
            wrAck       <= '0;
            intTagValid <= 1'b0;
            rdReqSent   <= 1'b0;
            capIsWr     <= 1'b0;
            tagTaken    <= 1'b0;
        end else begin
            rdAck       <= '0;         // One-cycle pulses
            wrAck       <= '0;
            intTagValid <= rdAccept;
            rdReqSent   <= rdAccept;
            case (state)
                RD_CHK: begin
                    if (rdAccept) begin
                        rdAck[rdChnl] <= 1'b1;
                        capIsWr       <= 1'b0;
                        state         <= CAP;
                    end else begin
                        state <= WR_CHK;
                    end
                end
                WR_CHK: begin
                    if (wrAccept) begin
                        wrAck[wrChnl] <= 1'b1;
                        capIsWr       <= 1'b1;
                        state         <= CAP;
                    end else begin
                        state <= RD_CHK;
                    end
                end
                CAP: begin
                    tagTaken <= 1'b0;
                    state    <= REL;
                end
                default: begin         // REL
                    tagTaken <= 1'b1;
                    if (issueTake)
                        state <= capIsWr ? RD_CHK : WR_CHK;  // Other kind goes first next
                end
            endcase
        end
    end

    // -----------------------------------------------
    // Captured request
    always_ff @(posedge CLK) begin
        if (rdAccept) begin
            capChnl <= rdChnl;
            capAddr <= rdPayload.addr;
            capLen  <= rdPayload.len;
            intTag  <= {rdPayload.sg, rdChnl};
        end else if (wrAccept) begin
            capChnl <= wrChnl;
            capAddr <= wrPayload.addr;
            capLen  <= wrPayload.len;
        end
        // Tag exchange answers two cycles after the read was accepted
        if (state == REL && !tagTaken)
            capTag <= capIsWr ? '0 : {{(`TXMUX_META_TAG_W - `TXMUX_EXT_TAG_W){1'b0}}, extTag};
    end

    assert property (@(posedge CLK) disable iff (!rstN)
        !((|rdAck) && (|wrAck)));

    // At most one channel per kind
    assert property (@(posedge CLK) disable iff (!rstN)
        $onehot0(rdAck) && $onehot0(wrAck));

endmodule

`default_nettype wire

/* hw/reqSelector.sv */
// Round-robin request selector that registers the chosen channel and its payload
`default_nettype none
`timescale 1ns/1ps
`include "txMuxSettings.svh"

module reqSelector #(
    parameter type payloadT = logic
) (
    input  wire logic                            CLK,
    input  wire logic                            rstN,
    input  wire logic [`TXMUX_NUM_CHNL-1:0]      reqAll,
    input  wire payloadT [`TXMUX_NUM_CHNL-1:0]   payloadAll,
    output logic                                 reqValid,
    output txMuxPkg::chnlT                       reqChnl,
    output payloadT                              reqPayload
);

    localparam int NC = `TXMUX_NUM_CHNL;

    txMuxPkg::chnlT ptr;         // Search start when nothing is shown
    txMuxPkg::chnlT searchBase;
    txMuxPkg::chnlT nextChnl;
    logic           nextValid;
    logic           hold;        // Shown channel still requesting

    assign hold = reqValid && reqAll[reqChnl];

    // Once the shown channel lets go, search again just past it
    always_comb begin
        if (!reqValid)
            searchBase = ptr;
        else if (reqChnl == txMuxPkg::chnlT'(NC - 1))
            searchBase = '0;
        else
            searchBase = reqChnl + 1'b1;
    end

    // Walk downward so the channel nearest the base wins
    always_comb begin
        int idx;
        nextValid = 1'b0;
        nextChnl  = searchBase;
        for (int i = NC - 1; i >= 0; i--) begin
            idx = int'(searchBase) + i;
            if (idx >= NC)
                idx = idx - NC;
            if (reqAll[idx]) begin
                nextValid = 1'b1;
                nextChnl  = txMuxPkg::chnlT'(idx);
            end
        end
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            ptr      <= '0;
            reqValid <= 1'b0;
            reqChnl  <= '0;
        end else if (!hold) begin
            ptr      <= searchBase;
            reqValid <= nextValid;
            reqChnl  <= nextChnl;
        end
    end

    always_ff @(posedge CLK) begin
        reqPayload <= payloadAll[hold ? reqChnl : nextChnl];  // Tracks the shown channel
    end

    // A shown channel was requesting in the cycle its choice was made
    assert property (@(posedge CLK) disable iff (!rstN)
        reqValid |-> (($past(reqAll) >> reqChnl) & 1) != 0);

endmodule

`default_nettype wire

/* hw/txIssue.sv */
// Issue FSM that sends one request header and streams the write payload downstream
`default_nettype none
`timescale 1ns/1ps
`include "txMuxSettings.svh"

module txIssue (
    input  wire logic                                 CLK,
    input  wire logic                                 rstN,
    input  wire logic                                 capPending,
    input  wire logic                                 capIsWr,
    input  wire txMuxPkg::chnlT                       capChnl,
    input  wire txMuxPkg::addrT                       capAddr,
    input  wire txMuxPkg::lenT                        capLen,
    input  wire logic [`TXMUX_META_TAG_W-1:0]         capTag,
    input  wire logic                                 metaReady,
    input  wire txMuxPkg::dataT [`TXMUX_NUM_CHNL-1:0] wrData,
    output logic                                      issueTake,
    output logic [`TXMUX_NUM_CHNL-1:0]                wrDataRen,
    output logic                                      metaValid,
    output txMuxPkg::reqTypeE                         metaType,
    output txMuxPkg::addrT                            metaAddr,
    output txMuxPkg::lenT                             metaLength,
    output logic [`TXMUX_META_TAG_W-1:0]              metaTag,
    output logic                                      dataValid,
    output txMuxPkg::dataT                            data,
    output logic                                      dataStart,
    output logic                                      dataEnd
);

    typedef enum logic [1:0] {
        IDLE,
        WR,
        WAIT
    } issueStateE;

    issueStateE     state;
    txMuxPkg::lenT  beatCnt;    // Words still to fetch
    txMuxPkg::chnlT dataChnl;
    logic [1:0]     waitCnt;
    logic           is64;

    assign is64       = |capAddr[`TXMUX_ADDR_W-1:32];
    assign issueTake  = (state == IDLE) && capPending && metaReady;
    assign metaValid  = issueTake;
    assign metaType   = capIsWr ? (is64 ? txMuxPkg::WR64 : txMuxPkg::WR32)
                                : (is64 ? txMuxPkg::RD64 : txMuxPkg::RD32);
    assign metaAddr   = capAddr;
    assign metaLength = capLen;
    assign metaTag    = capTag;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            state     <= IDLE;
            wrDataRen <= '0;
            waitCnt   <= '0;
            dataValid <= 1'b0;
            dataStart <= 1'b0;
            dataEnd   <= 1'b0;
        end else begin
            dataValid <= 1'b0;
            dataStart <= 1'b0;
            dataEnd   <= 1'b0;
            case (state)
                IDLE: begin
                    if (issueTake && capIsWr) begin
                        wrDataRen[capChnl] <= 1'b1;
                        state              <= WR;
                    end else if (issueTake) begin
                        waitCnt <= is64 ? 2'd2 : 2'd1;  // Longer header for 64-bit
                        state   <= WAIT;
                    end
                end
                WR: begin
                    // Lane word is registered as the beat of this fetch
                    dataValid <= 1'b1;
                    dataStart <= !dataValid;           // First WR cycle follows idle
                    dataEnd   <= (beatCnt == 1);
                    if (beatCnt == 1) begin
                        wrDataRen <= '0;
                        waitCnt   <= 2'd1;
                        state     <= WAIT;
                    end
                end
                default: begin
                    if (waitCnt == 0)
                        state <= IDLE;
                    else
                        waitCnt <= waitCnt - 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (issueTake) begin
            beatCnt  <= capLen;
            dataChnl <= capChnl;
        end else if (state == WR) begin
            beatCnt <= beatCnt - 1'b1;
        end
        data <= wrData[dataChnl];
    end

    assert property (@(posedge CLK) disable iff (!rstN) metaValid |-> metaReady);

    // First write beat lands two cycles after its header
    assert property (@(posedge CLK) disable iff (!rstN)
        metaValid && capIsWr |-> ##2 dataValid && dataStart);

endmodule

`default_nettype wire

/* hw/txMux.sv */
// Upstream request multiplexer joining the channel selectors, capture and issue stages
`default_nettype none
`timescale 1ns/1ps
`include "txMuxSettings.svh"

module txMux (
    input  wire logic                                    CLK,
    input  wire logic                                    rstN,
    // Channel side
    input  wire logic [`TXMUX_NUM_CHNL-1:0]              rdReq,
    input  wire logic [`TXMUX_NUM_CHNL-1:0][`TXMUX_SG_W-1:0] rdSgChnl,
    input  wire txMuxPkg::addrT [`TXMUX_NUM_CHNL-1:0]    rdAddr,
    input  wire txMuxPkg::lenT [`TXMUX_NUM_CHNL-1:0]     rdLen,
    output wire logic [`TXMUX_NUM_CHNL-1:0]              rdAck,
    input  wire logic [`TXMUX_NUM_CHNL-1:0]              wrReq,
    input  wire txMuxPkg::addrT [`TXMUX_NUM_CHNL-1:0]    wrAddr,
    input  wire txMuxPkg::lenT [`TXMUX_NUM_CHNL-1:0]     wrLen,
    input  wire txMuxPkg::dataT [`TXMUX_NUM_CHNL-1:0]    wrData,
    output wire logic [`TXMUX_NUM_CHNL-1:0]              wrDataRen,
    output wire logic [`TXMUX_NUM_CHNL-1:0]              wrAck,
    // Tag exchange and receive space
    output wire logic [`TXMUX_INT_TAG_W-1:0]             intTag,
    output wire logic                                    intTagValid,
    input  wire logic [`TXMUX_EXT_TAG_W-1:0]             extTag,
    input  wire logic                                    extTagValid,
    output wire logic                                    rdReqSent,
    input  wire logic                                    rxBufSpaceAvail,
    // Downstream engine
    output wire logic                                    metaValid,
    output wire txMuxPkg::reqTypeE                       metaType,
    output wire txMuxPkg::addrT                          metaAddr,
    output wire txMuxPkg::lenT                           metaLength,
    output wire logic [`TXMUX_META_TAG_W-1:0]            metaTag,
    input  wire logic                                    metaReady,
    output wire logic                                    dataValid,
    output wire txMuxPkg::dataT                          data,
    output wire logic                                    dataStart,
    output wire logic                                    dataEnd
);

    wire txMuxPkg::rdPayloadT [`TXMUX_NUM_CHNL-1:0] rdPayloadAll;
    wire txMuxPkg::wrPayloadT [`TXMUX_NUM_CHNL-1:0] wrPayloadAll;

    wire logic                          rdValid;
    wire txMuxPkg::chnlT                rdChnl;
    wire txMuxPkg::rdPayloadT           rdPayload;
    wire logic                          wrValid;
    wire txMuxPkg::chnlT                wrChnl;
    wire txMuxPkg::wrPayloadT           wrPayload;

    wire logic                          issueTake;
    wire logic                          capPending;
    wire logic                          capIsWr;
    wire txMuxPkg::chnlT                capChnl;
    wire txMuxPkg::addrT                capAddr;
    wire txMuxPkg::lenT                 capLen;
    wire logic [`TXMUX_META_TAG_W-1:0]  capTag;

    // Gather per-channel fields into selector payloads
    for (genvar i = 0; i < `TXMUX_NUM_CHNL; i++) begin : gPack
        assign rdPayloadAll[i] = '{addr: rdAddr[i], len: rdLen[i], sg: rdSgChnl[i]};
        assign wrPayloadAll[i] = '{addr: wrAddr[i], len: wrLen[i]};
    end

    reqSelector #(
        .payloadT   (txMuxPkg::rdPayloadT)
    ) rdSel (
        .CLK        (CLK),
        .rstN       (rstN),
        .reqAll     (rdReq),
        .payloadAll (rdPayloadAll),
        .reqValid   (rdValid),
        .reqChnl    (rdChnl),
        .reqPayload (rdPayload)
    );

    reqSelector #(
        .payloadT   (txMuxPkg::wrPayloadT)
    ) wrSel (
        .CLK        (CLK),
        .rstN       (rstN),
        .reqAll     (wrReq),
        .payloadAll (wrPayloadAll),
        .reqValid   (wrValid),
        .reqChnl    (wrChnl),
        .reqPayload (wrPayload)
    );

    reqCapture u_capture (
        .CLK             (CLK),
        .rstN            (rstN),
        .rdValid         (rdValid),
        .rdChnl          (rdChnl),
        .rdPayload       (rdPayload),
        .wrValid         (wrValid),
        .wrChnl          (wrChnl),
        .wrPayload       (wrPayload),
        .extTag          (extTag),
        .extTagValid     (extTagValid),
        .rxBufSpaceAvail (rxBufSpaceAvail),
        .issueTake       (issueTake),
        .rdAck           (rdAck),
        .wrAck           (wrAck),
        .intTag          (intTag),
        .intTagValid     (intTagValid),
        .rdReqSent       (rdReqSent),
        .capPending      (capPending),
        .capIsWr         (capIsWr),
        .capChnl         (capChnl),
        .capAddr         (capAddr),
        .capLen          (capLen),
        .capTag          (capTag)
    );

    txIssue u_issue (
        .CLK        (CLK),
        .rstN       (rstN),
        .capPending (capPending),
        .capIsWr    (capIsWr),
        .capChnl    (capChnl),
        .capAddr    (capAddr),
        .capLen     (capLen),
        .capTag     (capTag),
        .metaReady  (metaReady),
        .wrData     (wrData),
        .issueTake  (issueTake),
        .wrDataRen  (wrDataRen),
        .metaValid  (metaValid),
        .metaType   (metaType),
        .metaAddr   (metaAddr),
        .metaLength (metaLength),
        .metaTag    (metaTag),
        .dataValid  (dataValid),
        .data       (data),
        .dataStart  (dataStart),
        .dataEnd    (dataEnd)
    );

endmodule

`default_nettype wire

/* hw/txMuxPkg.sv */
// Transmit multiplexer types for request payloads, header type and field widths
`default_nettype none
`include "txMuxSettings.svh"

package txMuxPkg;

    typedef logic [`TXMUX_CHNL_W-1:0] chnlT;
    typedef logic [`TXMUX_ADDR_W-1:0] addrT;
    typedef logic [`TXMUX_LEN_W-1:0]  lenT;
    typedef logic [`TXMUX_DATA_W-1:0] dataT;

    // Read request of 76 bits as carried by the read selector
    typedef struct packed {
        addrT                   addr;
        lenT                    len;
        logic [`TXMUX_SG_W-1:0] sg;
    } rdPayloadT;

    typedef struct packed {
        addrT addr;
        lenT  len;
    } wrPayloadT;  // 74 bits

    // 64-bit forms are used when any upper address bit is set
    typedef enum logic [1:0] {
        RD32 = 2'd0,
        RD64 = 2'd1,
        WR32 = 2'd2,
        WR64 = 2'd3
    } reqTypeE;

endpackage

`default_nettype wire

/* hw/txMuxSettings.svh */
// Transmit multiplexer settings for channel count and field widths
`ifndef TXMUX_SETTINGS_SVH
`define TXMUX_SETTINGS_SVH

// -----------------------------------------------
// Channel side
`define TXMUX_NUM_CHNL      12
`define TXMUX_CHNL_W        4
`define TXMUX_SG_W          2   // Scatter-gather list selector
`define TXMUX_ADDR_W        64  // Byte address
`define TXMUX_LEN_W         10  // Length in 32-bit words
`define TXMUX_DATA_W        32

// -----------------------------------------------
// Tags
`define TXMUX_EXT_TAG_W     5
`define TXMUX_META_TAG_W    8

// SG selector in the upper bits, channel index below
`define TXMUX_INT_TAG_W     (`TXMUX_SG_W + `TXMUX_CHNL_W)

`endif

/* tests/txMuxTb.sv */
// Testbench for the upstream request multiplexer with random channels and a downstream model
`default_nettype none
`timescale 1ns/1ps
`include "txMuxSettings.svh"

module txMuxTb;

    localparam int NC       = `TXMUX_NUM_CHNL;
    localparam int PER      = 6;                 // Requests per channel and kind
    localparam int TOTAL    = NC * PER * 2;
    localparam int LIMIT_NS = (TOTAL * 40 + 1000) * 4;

    logic                                  CLK;
    logic                                  rstN;
    logic [NC-1:0]                         rdReq;
    logic [NC-1:0][`TXMUX_SG_W-1:0]        rdSgChnl;
    txMuxPkg::addrT [NC-1:0]               rdAddr;
    txMuxPkg::lenT [NC-1:0]                rdLen;
    logic [NC-1:0]                         wrReq;
    txMuxPkg::addrT [NC-1:0]               wrAddr;
    txMuxPkg::lenT [NC-1:0]                wrLen;
    txMuxPkg::dataT [NC-1:0]               wrData;
    logic [`TXMUX_EXT_TAG_W-1:0]           extTag;
    logic                                  extTagValid;
    logic                                  rxBufSpaceAvail;
    logic                                  metaReady;
    wire logic [NC-1:0]                    rdAck;
    wire logic [NC-1:0]                    wrAck;
    wire logic [NC-1:0]                    wrDataRen;
    wire logic [`TXMUX_INT_TAG_W-1:0]      intTag;
    wire logic                             intTagValid;
    wire logic                             rdReqSent;
    wire logic                             metaValid;
    wire txMuxPkg::reqTypeE                metaType;
    wire txMuxPkg::addrT                   metaAddr;
    wire txMuxPkg::lenT                    metaLength;
    wire logic [`TXMUX_META_TAG_W-1:0]     metaTag;
    wire logic                             dataValid;
    wire txMuxPkg::dataT                   data;
    wire logic                             dataStart;
    wire logic                             dataEnd;

    // --------------------------------------------------
    // Channel and scoreboard state
    logic [31:0]          lfsr;
    int                   rdLeft[NC];
    int                   wrLeft[NC];
    int                   rdGap[NC];
    int                   wrGap[NC];
    logic [NC-1:0]        rdAcked;
    logic [NC-1:0]        wrAcked;
    txMuxPkg::dataT       wordBuf[NC][64];
    int                   wHead[NC];
    int                   wTail[NC];
    logic [NC-1:0]        seen[2][NC];       // Channels served while one waited
    txMuxPkg::reqTypeE    hdrTypeQ[$];
    txMuxPkg::addrT       hdrAddrQ[$];
    txMuxPkg::lenT        hdrLenQ[$];
    logic [7:0]           hdrTagQ[$];
    logic [33:0]          beatQ[$];          // {start, end, word}
    int                   renChQ[$];
    int                   renLeftQ[$];
    logic                 tagDue;
    logic                 prevTagOk;
    int                   errors;
    int                   issued;
    int                   cyc;

    txMux u_dut (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic txMuxPkg::addrT newAddr();
        logic [31:0] hi;
        logic [29:0] lo;
        hi = '0;
        if (randBits(1) != 0)
            hi = randBits(32) | 32'h1;          // Above 4 GiB
        lo = 30'(randBits(30));
        return {hi, lo, 2'b00};
    endfunction

    // Any upper address bit set selects the 64-bit form
    function automatic txMuxPkg::reqTypeE expType(input logic wr, input txMuxPkg::addrT a);
        if (a[63:32] != 0)
            return wr ? txMuxPkg::WR64 : txMuxPkg::RD64;
        return wr ? txMuxPkg::WR32 : txMuxPkg::RD32;
    endfunction

    task automatic reportMismatch(input string name, input logic [63:0] exp,
                                  input logic [63:0] got);
        errors++;
        $display("ERROR %s exp=%h got=%h at %0t", name, exp, got, $time);
    endtask

    task automatic reportFailure(input string msg);
        errors++;
        $display("Failure at %0t: %s", $time, msg);
    endtask

    task automatic checkQuiet();
        logic [NC*3+5:0] ctrl;
        ctrl = {rdAck, wrAck, wrDataRen, intTagValid, rdReqSent, metaValid,
                dataValid, dataStart, dataEnd};
        assert (ctrl == 0) else reportMismatch("reset controls", 0, 64'(ctrl));
    endtask

    // Round robin lets nobody take a second turn past a waiting channel
    task automatic checkFair(input int k, input int i, input logic [NC-1:0] reqs);
        for (int j = 0; j < NC; j++) begin
            if (j != i && reqs[j]) begin
                assert (!seen[k][j][i]) else reportFailure($sformatf(
                    "channel %0d acknowledged twice while channel %0d waited", i, j));
                seen[k][j][i] = 1'b1;
            end
        end
        seen[k][i] = '0;
    endtask

    // --------------------------------------------------
    // Channel model driven after the rising edge
    task automatic driveInputs();
        int L;
        for (int i = 0; i < NC; i++) begin
            if (rdAcked[i]) begin
                rdReq[i]   = 1'b0;
                rdAcked[i] = 1'b0;
                rdGap[i]   = (rdLeft[i] >= PER / 2) ? 0 : int'(randBits(2));
            end else if (!rdReq[i] && rdLeft[i] > 0) begin
                if (rdGap[i] > 0) begin
                    rdGap[i]--;
                end else begin
                    rdAddr[i]   = newAddr();
                    rdLen[i]    = txMuxPkg::lenT'(randBits(3) + 1);
                    rdSgChnl[i] = 2'(randBits(2));
                    rdReq[i]    = 1'b1;
                    rdLeft[i]--;
                    seen[0][i]  = '0;
                end
            end
            if (wrAcked[i]) begin
                wrReq[i]   = 1'b0;
                wrAcked[i] = 1'b0;
                wrGap[i]   = (wrLeft[i] >= PER / 2) ? 0 : int'(randBits(2));
            end else if (!wrReq[i] && wrLeft[i] > 0) begin
                if (wrGap[i] > 0) begin
                    wrGap[i]--;
                end else begin
                    L         = int'(randBits(3)) + 1;
                    wrAddr[i] = newAddr();
                    wrLen[i]  = txMuxPkg::lenT'(L);
                    for (int k = 0; k < L; k++) begin
                        wordBuf[i][wTail[i]] = randBits(32);
                        wTail[i]++;
                    end
                    wrReq[i]   = 1'b1;
                    wrLeft[i]--;
                    seen[1][i] = '0;
                end
            end
            wrData[i] = (wHead[i] < wTail[i]) ? wordBuf[i][wHead[i]] : '0;
        end
        extTag          = 5'(randBits(5));
        extTagValid     = randBits(2) != 0;
        rxBufSpaceAvail = randBits(2) != 0;
        metaReady       = randBits(2) != 0;
    endtask

    // --------------------------------------------------
    // Scoreboard sampled at the falling edge
    task automatic sampleOutputs();
        int L;
        if (tagDue) begin
            hdrTagQ.push_back({3'b000, extTag});     // Exchanged two cycles after accept
            tagDue = 1'b0;
        end
        if (rdAck != 0) begin
            assert (prevTagOk) else reportFailure("read acknowledged without tag or space");
            assert (intTagValid && rdReqSent)
                else reportFailure("read acknowledged without tag exchange pulse");
        end else begin
            assert (!intTagValid && !rdReqSent)
                else reportFailure("tag exchange pulse without read acknowledge");
        end
        for (int i = 0; i < NC; i++) begin
            if (rdAck[i]) begin
                assert (intTag == {rdSgChnl[i], 4'(i)})
                    else reportMismatch("intTag", {rdSgChnl[i], 4'(i)}, intTag);
                hdrTypeQ.push_back(expType(1'b0, rdAddr[i]));
                hdrAddrQ.push_back(rdAddr[i]);
                hdrLenQ.push_back(rdLen[i]);
                tagDue     = 1'b1;
                rdAcked[i] = 1'b1;
                checkFair(0, i, rdReq);
            end
            if (wrAck[i]) begin
                L = int'(wrLen[i]);
                hdrTypeQ.push_back(expType(1'b1, wrAddr[i]));
                hdrAddrQ.push_back(wrAddr[i]);
                hdrLenQ.push_back(wrLen[i]);
                hdrTagQ.push_back(8'h00);
                for (int k = 0; k < L; k++)
                    beatQ.push_back({k == 0, k == L - 1, wordBuf[i][wTail[i] - L + k]});
                renChQ.push_back(i);
                renLeftQ.push_back(L);
                wrAcked[i] = 1'b1;
                checkFair(1, i, wrReq);
            end
            if (wrDataRen[i])
                wHead[i]++;                          // Next word shows next cycle
        end
        if (wrDataRen != 0) begin
            if (renChQ.size() == 0) begin
                reportFailure("write data fetched with no write pending");
            end else begin
                assert (wrDataRen == NC'(1) << renChQ[0])
                    else reportMismatch("wrDataRen", NC'(1) << renChQ[0], wrDataRen);
                renLeftQ[0]--;
                if (renLeftQ[0] == 0) begin
                    void'(renChQ.pop_front());
                    void'(renLeftQ.pop_front());
                end
            end
        end
        if (metaValid) begin
            assert (metaReady) else reportFailure("metaValid high while metaReady low");
            if (hdrTypeQ.size() == 0 || hdrTagQ.size() == 0) begin
                reportFailure("header sent with no acknowledged request");
            end else begin
                assert (metaType == hdrTypeQ[0])
                    else reportMismatch("metaType", 64'(hdrTypeQ[0]), 64'(metaType));
                assert (metaAddr == hdrAddrQ[0])
                    else reportMismatch("metaAddr", hdrAddrQ[0], metaAddr);
                assert (metaLength == hdrLenQ[0])
                    else reportMismatch("metaLength", 64'(hdrLenQ[0]), 64'(metaLength));
                assert (metaTag == hdrTagQ[0])
                    else reportMismatch("metaTag", 64'(hdrTagQ[0]), 64'(metaTag));
                void'(hdrTypeQ.pop_front());
                void'(hdrAddrQ.pop_front());
                void'(hdrLenQ.pop_front());
                void'(hdrTagQ.pop_front());
                issued++;
            end
        end
        if (dataValid) begin
            if (beatQ.size() == 0) begin
                reportFailure("data beat with no write data expected");
            end else begin
                assert ({dataStart, dataEnd, data} == beatQ[0])
                    else reportMismatch("data beat", beatQ[0], {dataStart, dataEnd, data});
                void'(beatQ.pop_front());
            end
        end
        prevTagOk = extTagValid && rxBufSpaceAvail;
    endtask

    function automatic logic allDone();
        for (int i = 0; i < NC; i++)
            if (rdLeft[i] != 0 || wrLeft[i] != 0)
                return 1'b0;
        return rdReq == 0 && wrReq == 0 && rdAcked == 0 && wrAcked == 0 &&
               hdrTypeQ.size() == 0 && beatQ.size() == 0 && renChQ.size() == 0;
    endfunction

    // --------------------------------------------------
    // Main sequence
    initial begin
        lfsr = 32'had84_a04d;
        rstN = 1'b0;
        rdReq = '0;
        rdSgChnl = '0;
        rdAddr = '0;
        rdLen = '0;
        wrReq = '0;
        wrAddr = '0;
        wrLen = '0;
        wrData = '0;
        extTag = '0;
        extTagValid = 1'b0;
        rxBufSpaceAvail = 1'b0;
        metaReady = 1'b0;
        rdAcked = '0;
        wrAcked = '0;
        tagDue = 1'b0;
        prevTagOk = 1'b0;
        errors = 0;
        issued = 0;
        cyc = 0;
        for (int i = 0; i < NC; i++) begin
            rdLeft[i] = PER;
            wrLeft[i] = PER;
            rdGap[i]  = int'(randBits(2));     // Staggered start times
            wrGap[i]  = int'(randBits(2));
            wHead[i]  = 0;
            wTail[i]  = 0;
            seen[0][i] = '0;
            seen[1][i] = '0;
        end
        repeat (5) begin
            @(posedge CLK);
            @(negedge CLK);
            checkQuiet();
        end
        while (!allDone()) begin
            @(posedge CLK);
            #1;
            rstN = 1'b1;
            driveInputs();
            @(negedge CLK);
            if (cyc < 2)
                checkQuiet();
            sampleOutputs();
            cyc++;
        end
        repeat (10) begin
            @(posedge CLK);
            #1;
            driveInputs();
            @(negedge CLK);
            sampleOutputs();
        end
        assert (issued == TOTAL) else reportMismatch("headers issued", TOTAL, issued);
        assert (hdrTypeQ.size() == 0 && hdrTagQ.size() == 0 && beatQ.size() == 0)
            else reportFailure("expected headers or beats left over");
        $display("Errors: %0d, headers issued: %0d of %0d", errors, issued, TOTAL);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // Watchdog
    initial begin
        #(LIMIT_NS);
        $display("Timeout: run stopped with %0d of %0d headers issued", issued, TOTAL);
        $display("Errors: %0d", errors);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire
